//--- design/drive_pkg.sv
package drive_pkg;

	////////////////////////////////////////
	// Field widths
	////////////////////////////////////////

	localparam int PWR_W = 3;
	localparam int DIR_W = 2;
	localparam int BTN_W = 5;
	localparam int SW_W  = 8;

	// Switch bit that selects manual driving
	localparam int MANUAL_BIT = 7;

	typedef logic [BTN_W-1:0] button_t;
	typedef logic [SW_W-1:0]  switch_t;

	// Robot motions, codes as on the original board
	typedef enum logic [4:0] {
		MV_NEUTRAL       = 5'b00000,
		MV_FORWARD       = 5'b00001,
		MV_REVERSE       = 5'b00010,
		MV_FORWARD_RIGHT = 5'b00011,
		MV_BACK_RIGHT    = 5'b00111,
		MV_FORWARD_LEFT  = 5'b11000,
		MV_BACK_LEFT     = 5'b10000,
		MV_R_360         = 5'b10011,
		MV_L_360         = 5'b11001
	} motion_t;

	////////////////////////////////////////
	// Motor command word
	////////////////////////////////////////

	// Per-motor direction field
	typedef logic [DIR_W-1:0] motor_dir_t;
	localparam motor_dir_t DIR_FORWARD = 2'b00;
	localparam motor_dir_t DIR_NEUTRAL = 2'b01;
	localparam motor_dir_t DIR_REVERSE = 2'b10;

	// Duty levels 13, 17, 25, 38, 50 and 62 %
	typedef logic [PWR_W-1:0] power_t;
	localparam power_t PWR_MIN = 3'd0;
	localparam power_t PWR_MAX = 3'd5;

	// Power on top, direction in the low bits
	typedef logic [PWR_W+DIR_W-1:0] motor_cmd_t;
	localparam motor_cmd_t MOTOR_IDLE = {PWR_MIN, DIR_NEUTRAL};

	function automatic motor_cmd_t motor_word(power_t pwr, motor_dir_t dir);
		return {pwr, dir};
	endfunction

endpackage

//--- design/nav_pkg.sv
package nav_pkg;

	////////////////////////////////////////
	// Sensor values and commands
	////////////////////////////////////////

	localparam int DIST_W = 8;
	localparam int CMD_W  = 5;

	// One range reading
	typedef logic [DIST_W-1:0] dist_t;

	// High-level command from the route planner
	typedef logic [CMD_W-1:0] command_t;

	// Only straight is decoded, anything else idles
	localparam command_t CMD_STRAIGHT = 5'b01110;

	////////////////////////////////////////
	// Navigation FSM
	////////////////////////////////////////

	// Codes also shown on the LEDs
	typedef enum logic [2:0] {
		NAV_UNDETERMINED  = 3'd0,
		NAV_BOTH_EQUAL    = 3'd1,
		NAV_BOTH_LESS     = 3'd2,
		NAV_BOTH_GREATER  = 3'd3,
		NAV_FRONT_LESS    = 3'd4,
		NAV_FRONT_GREATER = 3'd5,
		NAV_FRONT_EQUAL   = 3'd6,
		NAV_GOAL          = 3'd7
	} nav_state_t;

	// Default closest allowed distance
	localparam dist_t CRASH_LIMIT_DEF = 8'd3;
	// Default back/front alignment offset
	localparam dist_t ALIGN_TOL_DEF   = 8'd2;

endpackage

//--- design/sensor_if.sv
`timescale 1ns/1ps

// Range readings for the wall follower
interface sensor_if;
	import nav_pkg::*;

	// Obstacle straight ahead
	dist_t dist_front;
	// Wall side, front and rear sensor
	dist_t dist_side_front;
	dist_t dist_side_back;
	// Wanted wall distance
	dist_t path;
	// Front distance where the run ends
	dist_t dist_check;

	// Levels only, no handshake
	modport source (
		output dist_front, dist_side_front, dist_side_back, path, dist_check
	);

	modport follower (
		input dist_front, dist_side_front, dist_side_back, path, dist_check
	);

endinterface

//--- design/wall_follower.sv
`timescale 1ns/1ps

module wall_follower #(
	parameter nav_pkg::dist_t CRASH_LIMIT = nav_pkg::CRASH_LIMIT_DEF,
	parameter nav_pkg::dist_t ALIGN_TOL   = nav_pkg::ALIGN_TOL_DEF
) (
	input  logic                 CLK,
	input  logic                 rst_n,
	sensor_if.follower           sens,
	input  nav_pkg::command_t    command,
	input  logic                 run,
	output drive_pkg::motion_t   auto_motion,
	output logic                 goal,
	output nav_pkg::nav_state_t  nav_state
);
	import nav_pkg::*;
	import drive_pkg::*;

	dist_t      sf;
	dist_t      sb;
	dist_t      df;
	dist_t      pth;
	logic       straight_run;
	logic       at_check;
	// Sorting of the side sensors against path
	logic       cond_equal;
	logic       cond_less;
	logic       cond_greater;
	logic       cond_f_less;
	logic       cond_f_greater;
	logic       cond_f_equal;
	// Too close, strict and inclusive variants
	logic       near_lt;
	logic       near_le;
	motion_t    back_off_lt;
	motion_t    back_off_le;
	// Side alignment
	dist_t      diff_bf;
	dist_t      diff_fb;
	motion_t    align_greater;
	motion_t    align_less;
	nav_state_t state_d;
	motion_t    motion_d;
	logic       goal_d;

	assign sf  = sens.dist_side_front;
	assign sb  = sens.dist_side_back;
	assign df  = sens.dist_front;
	assign pth = sens.path;

	assign straight_run = run && (command == CMD_STRAIGHT);
	assign at_check     = df <= sens.dist_check;

	assign cond_equal     = (sf == pth) && (sb == pth);
	assign cond_less      = (sf < pth) && (sb < pth);
	assign cond_greater   = (sf > pth) && (sb > pth);
	assign cond_f_less    = (sf < pth) && (sb >= pth);
	assign cond_f_greater = (sf > pth) && (sb <= pth);
	// Held with the back off path on either side
	assign cond_f_equal   = (sf == pth) && (sb != pth);

	assign near_lt = (df < CRASH_LIMIT) || (sf < CRASH_LIMIT) || (sb < CRASH_LIMIT);
	assign near_le = (df <= CRASH_LIMIT) || (sf <= CRASH_LIMIT) || (sb <= CRASH_LIMIT);
	// Rear sensor close means pull forward
	assign back_off_lt = (sb < CRASH_LIMIT) ? MV_FORWARD : MV_BACK_RIGHT;
	assign back_off_le = (sb <= CRASH_LIMIT) ? MV_FORWARD : MV_BACK_RIGHT;

	////////////////////////////////////////
	// Alignment against the wall
	////////////////////////////////////////

	assign diff_bf = sb - sf;
	assign diff_fb = sf - sb;

	// Both far, rear drifted out
	always_comb begin
		if ((sb > sf) && (diff_bf > ALIGN_TOL))
			align_greater = MV_BACK_RIGHT;
		else if ((sb > sf) && (diff_bf == ALIGN_TOL))
			align_greater = MV_FORWARD;
		else
			align_greater = MV_FORWARD_LEFT;
	end

	// Both near, mirror of the far case
	always_comb begin
		if ((sf > sb) && (diff_fb > ALIGN_TOL))
			align_less = MV_FORWARD_LEFT;
		else if ((sf > sb) && (diff_fb == ALIGN_TOL))
			align_less = MV_FORWARD;
		else
			align_less = MV_FORWARD_RIGHT;
	end

	////////////////////////////////////////
	// Navigation FSM
	////////////////////////////////////////

	always_comb begin
		state_d  = nav_state;
		motion_d = MV_NEUTRAL;
		goal_d   = 1'b0;
		if (!straight_run) begin
			state_d = NAV_UNDETERMINED;
		end else if (at_check) begin
			// Front check wins over everything else
			state_d = NAV_GOAL;
			goal_d  = 1'b1;
		end else begin
			case (nav_state)
				NAV_UNDETERMINED: begin
					// Same test order as the original board
					if (cond_equal)
						state_d = NAV_BOTH_EQUAL;
					else if (cond_less)
						state_d = NAV_BOTH_LESS;
					else if (cond_greater)
						state_d = NAV_BOTH_GREATER;
					else if (cond_f_less)
						state_d = NAV_FRONT_LESS;
					else if (cond_f_greater)
						state_d = NAV_FRONT_GREATER;
					else if (cond_f_equal && (sb < pth))
						state_d = NAV_FRONT_EQUAL;
				end
				NAV_BOTH_EQUAL: begin
					if (near_lt)
						motion_d = back_off_lt;
					else if (cond_equal)
						motion_d = MV_FORWARD;
					else
						state_d = NAV_UNDETERMINED;
				end
				NAV_FRONT_LESS: begin
					if (near_lt)
						motion_d = back_off_lt;
					else if (cond_f_less)
						motion_d = MV_BACK_RIGHT;
					else
						state_d = NAV_UNDETERMINED;
				end
				NAV_FRONT_GREATER: begin
					if (near_lt)
						motion_d = back_off_lt;
					else if (cond_f_greater)
						motion_d = MV_FORWARD_LEFT;
					else
						state_d = NAV_UNDETERMINED;
				end
				NAV_FRONT_EQUAL: begin
					if (near_lt)
						motion_d = back_off_lt;
					else if (cond_f_equal)
						motion_d = MV_FORWARD;
					else
						state_d = NAV_UNDETERMINED;
				end
				NAV_BOTH_GREATER: begin
					if (near_lt)
						motion_d = back_off_lt;
					else if (cond_greater)
						motion_d = align_greater;
					else
						state_d = NAV_UNDETERMINED;
				end
				NAV_BOTH_LESS: begin
					// Inclusive limit, the wall is already close
					if (near_le)
						motion_d = back_off_le;
					else if (cond_less)
						motion_d = align_less;
					else
						state_d = NAV_UNDETERMINED;
				end
				NAV_GOAL: begin
					// Front cleared again
					state_d = NAV_UNDETERMINED;
				end
			endcase
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			nav_state   <= NAV_UNDETERMINED;
			auto_motion <= MV_NEUTRAL;
			goal        <= 1'b0;
		end else begin
			nav_state   <= state_d;
			auto_motion <= motion_d;
			goal        <= goal_d;
		end
	end

endmodule

//--- design/motion_select.sv
`timescale 1ns/1ps

module motion_select (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                manual,
	input  drive_pkg::button_t  buttons,
	input  drive_pkg::motion_t  auto_motion,
	output drive_pkg::motion_t  motion
);
	import drive_pkg::*;

	motion_t btn_motion;
	motion_t motion_d;

	////////////////////////////////////////
	// Button decode
	////////////////////////////////////////

	// One-hot only, chords fall to neutral
	always_comb begin
		case (buttons)
			5'b00001:
				btn_motion = MV_FORWARD_RIGHT;
			5'b00010:
				btn_motion = MV_REVERSE;
			5'b00100:
				btn_motion = MV_FORWARD;
			5'b01000:
				btn_motion = MV_FORWARD_LEFT;
			5'b10000:
				btn_motion = MV_R_360;
			default:
				btn_motion = MV_NEUTRAL;
		endcase
	end

	////////////////////////////////////////
	// Mode select
	////////////////////////////////////////

	// Manual overrides the wall follower
	assign motion_d = manual ? btn_motion : auto_motion;

	// One cycle from button to motion
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			motion <= MV_NEUTRAL;
		else
			motion <= motion_d;
	end

endmodule

//--- design/motor_driver.sv
`timescale 1ns/1ps

module motor_driver (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  drive_pkg::switch_t     switches,
	input  drive_pkg::motion_t     motion,
	output drive_pkg::motor_cmd_t  mc_right,
	output drive_pkg::motor_cmd_t  mc_left
);
	import drive_pkg::*;

	power_t     power_q;
	motor_dir_t dir_right;
	motor_dir_t dir_left;

	////////////////////////////////////////
	// Power level
	////////////////////////////////////////

	// Whole byte must be 1..5, else lowest duty
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			power_q <= PWR_MIN;
		else if ((switches != '0) && (switches <= switch_t'(PWR_MAX)))
			power_q <= switches[PWR_W-1:0];
		else
			power_q <= PWR_MIN;
	end

	////////////////////////////////////////
	// Direction decode
	////////////////////////////////////////

	// Right motor is motor 1, left is motor 2
	always_comb begin
		dir_right = DIR_NEUTRAL;
		dir_left  = DIR_NEUTRAL;
		case (motion)
			MV_FORWARD: begin
				dir_right = DIR_FORWARD;
				dir_left  = DIR_FORWARD;
			end
			MV_REVERSE: begin
				dir_right = DIR_REVERSE;
				dir_left  = DIR_REVERSE;
			end
			MV_FORWARD_RIGHT:
				dir_left = DIR_FORWARD;
			MV_BACK_RIGHT:
				dir_right = DIR_REVERSE;
			MV_FORWARD_LEFT:
				dir_right = DIR_FORWARD;
			MV_BACK_LEFT:
				dir_left = DIR_REVERSE;
			// Spin in place
			MV_R_360: begin
				dir_right = DIR_REVERSE;
				dir_left  = DIR_FORWARD;
			end
			MV_L_360: begin
				dir_right = DIR_FORWARD;
				dir_left  = DIR_REVERSE;
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			mc_right <= MOTOR_IDLE;
			mc_left  <= MOTOR_IDLE;
		end else begin
			mc_right <= motor_word(power_q, dir_right);
			mc_left  <= motor_word(power_q, dir_left);
		end
	end

endmodule

//--- design/robot_drive_top.sv
`timescale 1ns/1ps

module robot_drive_top #(
	parameter nav_pkg::dist_t CRASH_LIMIT = nav_pkg::CRASH_LIMIT_DEF,
	parameter nav_pkg::dist_t ALIGN_TOL   = nav_pkg::ALIGN_TOL_DEF
) (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  drive_pkg::switch_t     sw,
	input  drive_pkg::button_t     btn,
	input  nav_pkg::dist_t         dist_front,
	input  nav_pkg::dist_t         dist_side_front,
	input  nav_pkg::dist_t         dist_side_back,
	input  nav_pkg::dist_t         path,
	input  nav_pkg::dist_t         dist_check,
	input  nav_pkg::command_t      command,
	input  logic                   run,
	output drive_pkg::motor_cmd_t  mc_right,
	output drive_pkg::motor_cmd_t  mc_left,
	output logic                   next_flag,
	output nav_pkg::nav_state_t    led
);
	import drive_pkg::*;

	motion_t auto_motion;
	motion_t motion;

	////////////////////////////////////////
	// Sensor bundle
	////////////////////////////////////////

	sensor_if sens ();

	assign sens.dist_front      = dist_front;
	assign sens.dist_side_front = dist_side_front;
	assign sens.dist_side_back  = dist_side_back;
	assign sens.path            = path;
	assign sens.dist_check      = dist_check;

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	wall_follower #(
		.CRASH_LIMIT (CRASH_LIMIT),
		.ALIGN_TOL   (ALIGN_TOL)
	) i_wall_follower (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.sens        (sens.follower),
		.command     (command),
		.run         (run),
		.auto_motion (auto_motion),
		.goal        (next_flag),
		.nav_state   (led)
	);

	// Switch bit 7 selects manual driving
	motion_select i_motion_select (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.manual      (sw[MANUAL_BIT]),
		.buttons     (btn),
		.auto_motion (auto_motion),
		.motion      (motion)
	);

	motor_driver i_motor_driver (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.switches (sw),
		.motion   (motion),
		.mc_right (mc_right),
		.mc_left  (mc_left)
	);

endmodule

//--- dv/robot_drive_asserts.sv
`timescale 1ns/1ps

module robot_drive_asserts (
	input logic                   CLK,
	input logic                   rst_n,
	input drive_pkg::motor_cmd_t  mc_right,
	input drive_pkg::motor_cmd_t  mc_left,
	input logic                   next_flag,
	input nav_pkg::nav_state_t    led
);
	import drive_pkg::*;
	import nav_pkg::*;

	// Number of failed properties
	int fail_count = 0;

	// Code 11 is not a direction
	dir_legal: assert property (@(posedge CLK) disable iff (!rst_n)
		(mc_right[DIR_W-1:0] != 2'b11) && (mc_left[DIR_W-1:0] != 2'b11))
		else begin
			$error("motor direction field holds the unused code 11");
			fail_count++;
		end

	// Flag and LED come from the same FSM register
	goal_led: assert property (@(posedge CLK) disable iff (!rst_n)
		next_flag |-> (led == NAV_GOAL))
		else begin
			$error("goal flag high while the LEDs do not show the goal state");
			fail_count++;
		end

	// Words trail the flag by the motion and word registers
	goal_stop: assert property (@(posedge CLK) disable iff (!rst_n)
		(next_flag && $past(next_flag) && $past(next_flag, 2)) |->
		((mc_right[DIR_W-1:0] == DIR_NEUTRAL) && (mc_left[DIR_W-1:0] == DIR_NEUTRAL)))
		else begin
			$error("motors still driven while the goal flag is held");
			fail_count++;
		end

endmodule

bind robot_drive_top robot_drive_asserts i_robot_drive_asserts (
	.CLK       (CLK),
	.rst_n     (rst_n),
	.mc_right  (mc_right),
	.mc_left   (mc_left),
	.next_flag (next_flag),
	.led       (led)
);

//--- dv/robot_drive_tasks.svh
////////////////////////////////////////
// Stimulus values
////////////////////////////////////////

localparam dist_t    FAR_DIST   = 8'd200;
localparam dist_t    PATH_DIST  = 8'd20;
localparam dist_t    CHECK_DIST = 8'd10;
// Power used for the automatic runs
localparam switch_t  RUN_SW     = 8'd3;
localparam power_t   RUN_PWR    = 3'd3;
// Anything but straight
localparam command_t IDLE_CMD   = 5'b00110;

// Power in the top three bits, direction below
function automatic motor_cmd_t expected_word(power_t pwr, motor_dir_t dir);
	return {pwr, dir};
endfunction

// Outputs settle on the edge, sample with the drive delay
task automatic wait_edges(int n);
	repeat (n) @(posedge CLK);
	#DRIVE_DLY;
endtask

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic check_motor(string test, string motor, motor_cmd_t exp, motor_cmd_t act);
	if (act !== exp) begin
		$display("mismatch %s %s motor: expected pwr %0d dir %b, actual pwr %0d dir %b",
			test, motor, exp[4:2], exp[1:0], act[4:2], act[1:0]);
		motor_errors++;
	end
endtask

task automatic check_state(string test, nav_state_t exp, nav_state_t act);
	if (act !== exp) begin
		$display("mismatch %s led: expected %s (%0d), actual %s (%0d)",
			test, exp.name(), exp, act.name(), act);
		state_errors++;
	end
endtask

task automatic check_flag(string test, logic exp, logic act);
	if (act !== exp) begin
		$display("mismatch %s next_flag: expected %b, actual %b", test, exp, act);
		flag_errors++;
	end
endtask

task automatic check_outputs(string test, power_t pwr, motor_dir_t dr, motor_dir_t dl,
	nav_state_t st, logic flag);
	check_motor(test, "right", expected_word(pwr, dr), mc_right);
	check_motor(test, "left", expected_word(pwr, dl), mc_left);
	check_state(test, st, led);
	check_flag(test, flag, next_flag);
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic test_reset();
	check_outputs("reset", 3'd0, DIR_NEUTRAL, DIR_NEUTRAL, NAV_UNDETERMINED, 1'b0);
endtask

// Bit 7 set, byte out of range, so lowest power
task automatic manual_case(string name, button_t b, motor_dir_t dr, motor_dir_t dl);
	sw  = 8'h80;
	btn = b;
	wait_edges(2);
	check_motor(name, "right", expected_word(3'd0, dr), mc_right);
	check_motor(name, "left", expected_word(3'd0, dl), mc_left);
	wait_edges(4);
	check_outputs(name, 3'd0, dr, dl, NAV_UNDETERMINED, 1'b0);
endtask

task automatic test_manual();
	manual_case("manual fwd_right", 5'b00001, DIR_NEUTRAL, DIR_FORWARD);
	manual_case("manual reverse", 5'b00010, DIR_REVERSE, DIR_REVERSE);
	manual_case("manual forward", 5'b00100, DIR_FORWARD, DIR_FORWARD);
	manual_case("manual fwd_left", 5'b01000, DIR_FORWARD, DIR_NEUTRAL);
	manual_case("manual r_360", 5'b10000, DIR_REVERSE, DIR_FORWARD);
	// Two buttons at once
	manual_case("manual chord", 5'b00011, DIR_NEUTRAL, DIR_NEUTRAL);
endtask

task automatic power_case(switch_t s, power_t lvl);
	sw  = s;
	btn = '0;
	run = 1'b0;
	wait_edges(6);
	check_outputs($sformatf("power sw=%02h", s), lvl, DIR_NEUTRAL, DIR_NEUTRAL,
		NAV_UNDETERMINED, 1'b0);
endtask

task automatic test_power();
	power_case(8'd1, 3'd1);
	power_case(8'd2, 3'd2);
	power_case(8'd3, 3'd3);
	power_case(8'd4, 3'd4);
	power_case(8'd5, 3'd5);
	// Out of range bytes
	power_case(8'd0, 3'd0);
	power_case(8'd6, 3'd0);
	power_case(8'h21, 3'd0);
endtask

task automatic auto_case(string name, dist_t front, dist_t sf, dist_t sb,
	nav_state_t st, logic flag, motor_dir_t dr, motor_dir_t dl);
	dist_front      = front;
	dist_side_front = sf;
	dist_side_back  = sb;
	wait_edges(6);
	check_outputs(name, RUN_PWR, dr, dl, st, flag);
endtask

task automatic test_straight();
	sw         = RUN_SW;
	btn        = '0;
	path       = PATH_DIST;
	dist_check = CHECK_DIST;
	command    = CMD_STRAIGHT;
	run        = 1'b1;
	auto_case("straight equal", FAR_DIST, PATH_DIST, PATH_DIST, NAV_BOTH_EQUAL, 1'b0,
		DIR_FORWARD, DIR_FORWARD);
	// Rear 5 further out than front
	auto_case("straight drift 5", FAR_DIST, 8'd25, 8'd30, NAV_BOTH_GREATER, 1'b0,
		DIR_REVERSE, DIR_NEUTRAL);
	// Exactly at the tolerance
	auto_case("straight drift 2", FAR_DIST, 8'd25, 8'd27, NAV_BOTH_GREATER, 1'b0,
		DIR_FORWARD, DIR_FORWARD);
endtask

task automatic test_goal();
	auto_case("goal at check", CHECK_DIST, 8'd25, 8'd27, NAV_GOAL, 1'b1,
		DIR_NEUTRAL, DIR_NEUTRAL);
	auto_case("goal cleared", FAR_DIST, 8'd25, 8'd27, NAV_BOTH_GREATER, 1'b0,
		DIR_FORWARD, DIR_FORWARD);
endtask

task automatic test_idle();
	run = 1'b0;
	auto_case("idle run low", FAR_DIST, 8'd25, 8'd30, NAV_UNDETERMINED, 1'b0,
		DIR_NEUTRAL, DIR_NEUTRAL);
	// Front inside the check distance, still no goal
	run     = 1'b1;
	command = IDLE_CMD;
	auto_case("idle other command", 8'd5, 8'd25, 8'd30, NAV_UNDETERMINED, 1'b0,
		DIR_NEUTRAL, DIR_NEUTRAL);
endtask

//--- dv/robot_drive_tb.sv
`timescale 1ns/1ps

module robot_drive_tb;
	import drive_pkg::*;
	import nav_pkg::*;

	localparam int HALF_PERIOD = 20;
	localparam int DRIVE_DLY   = 2;
	// Directed cases in the sequence below
	localparam int N_TESTS      = 22;
	localparam int WATCH_CYCLES = N_TESTS * 20 + 50;

	logic       CLK = 1'b0;
	logic       rst_n;
	switch_t    sw;
	button_t    btn;
	dist_t      dist_front;
	dist_t      dist_side_front;
	dist_t      dist_side_back;
	dist_t      path;
	dist_t      dist_check;
	command_t   command;
	logic       run;
	motor_cmd_t mc_right;
	motor_cmd_t mc_left;
	logic       next_flag;
	nav_state_t led;

	int motor_errors;
	int state_errors;
	int flag_errors;
	int assert_errors;

	always #HALF_PERIOD CLK = ~CLK;

	robot_drive_top #(
		.CRASH_LIMIT (CRASH_LIMIT_DEF),
		.ALIGN_TOL   (ALIGN_TOL_DEF)
	) i_robot_drive_top (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.sw              (sw),
		.btn             (btn),
		.dist_front      (dist_front),
		.dist_side_front (dist_side_front),
		.dist_side_back  (dist_side_back),
		.path            (path),
		.dist_check      (dist_check),
		.command         (command),
		.run             (run),
		.mc_right        (mc_right),
		.mc_left         (mc_left),
		.next_flag       (next_flag),
		.led             (led)
	);

	`include "robot_drive_tasks.svh"

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		motor_errors    = 0;
		state_errors    = 0;
		flag_errors     = 0;
		assert_errors   = 0;
		rst_n           = 1'b0;
		sw              = '0;
		btn             = '0;
		dist_front      = '0;
		dist_side_front = '0;
		dist_side_back  = '0;
		path            = '0;
		dist_check      = '0;
		command         = '0;
		run             = 1'b0;
		// Two cycles in reset
		repeat (2) @(posedge CLK);
		#DRIVE_DLY;
		rst_n = 1'b1;
		test_reset();
		test_manual();
		test_power();
		test_straight();
		test_goal();
		test_idle();
		// Failed bound properties
		assert_errors = i_robot_drive_top.i_robot_drive_asserts.fail_count;
		$display("errors: motor %0d, state %0d, flag %0d, assert %0d, total %0d",
			motor_errors, state_errors, flag_errors, assert_errors,
			motor_errors + state_errors + flag_errors + assert_errors);
		if ((motor_errors + state_errors + flag_errors + assert_errors) == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCH_CYCLES) @(posedge CLK);
		$display("timeout: test sequence still running after %0d cycles", WATCH_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- list.f
+incdir+dv
design/drive_pkg.sv
design/nav_pkg.sv
design/sensor_if.sv
design/wall_follower.sv
design/motion_select.sv
design/motor_driver.sv
design/robot_drive_top.sv
dv/robot_drive_asserts.sv
dv/robot_drive_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = robot_drive_tb
FILE_LIST = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
